// ==== common/cpuArchPkg.sv ====
`default_nettype none

package cpuArchPkg;

    typedef logic [7:0] dataWord;     // Register and ALU value
    typedef logic [7:0] progAddress;  // Program byte address, also the PC
    typedef logic [1:0] regIndex;     // 0 is R1, 3 is R4

    // 1010 and 1101 to 1111 are unused
    typedef enum logic [3:0] {
        opAnd = 4'b0000,
        opOr  = 4'b0001,
        opNot = 4'b0010,
        opAdd = 4'b0011,
        opSub = 4'b0100,
        opLsr = 4'b0101,
        opLsl = 4'b0110,
        opInc = 4'b0111,
        opDec = 4'b1000,
        opBra = 4'b1001,
        opMov = 4'b1011,
        opLd  = 4'b1100
    } opcode;

    // Immediate and branch address are srcFirst and srcSecond together
    typedef struct packed {
        opcode      code;       // Bits 15:12
        logic [3:0] dst;        // Bits 11:8, LD uses 9:8
        logic [3:0] srcFirst;   // Bits 7:4
        logic [3:0] srcSecond;  // Bits 3:0
    } instruction;

    typedef struct packed {
        dataWord r1;
        dataWord r2;
        dataWord r3;
        dataWord r4;
    } registerView;

endpackage

`default_nettype wire

// ==== common/cpuControlPkg.sv ====
`default_nettype none

package cpuControlPkg;

    import cpuArchPkg::*;

    // ALU function select codes
    typedef enum logic [3:0] {
        aluPassA   = 4'b0000,
        aluPassImm = 4'b0001,
        aluNot     = 4'b0010,
        aluAdd     = 4'b0100,
        aluSub     = 4'b0101,
        aluAnd     = 4'b0111,
        aluOr      = 4'b1000,
        aluLsl     = 4'b1011,
        aluLsr     = 4'b1100
    } aluOp;

    // Register function select
    typedef enum logic [1:0] {
        rfHold      = 2'b00,
        rfLoad      = 2'b01,
        rfDecrement = 2'b10,
        rfIncrement = 2'b11
    } regFunc;

    typedef enum logic [1:0] {
        stIdle,
        stFetchLow,
        stFetchHigh,
        stExecute
    } seqState;

    // 21 bits in total
    typedef struct packed {
        regFunc  regFn;
        regIndex target;     // Register that applies regFn
        regIndex srcA;
        regIndex srcB;
        aluOp    op;
        dataWord immediate;  // LD value or BRA address
        logic    pcLoad;
    } controlWord;

endpackage

`default_nettype wire

// ==== controlUnit/controlSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlSequencer
    import cpuArchPkg::*, cpuControlPkg::*;
(
    input  wire logic       clock,
    input  wire logic       arstN,
    input  wire logic       run,
    input  wire dataWord    fetchByte,
    input  wire controlWord ctrl,
    output progAddress      fetchAddr,
    output instruction      ir,
    output logic            execute,
    output progAddress      pc,
    output logic            instrDone
);

    seqState state;

    assign fetchAddr = pc;
    assign execute   = (state == stExecute);
    assign instrDone = (state == stExecute);  // One cycle per instruction

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            pc    <= '0;
            ir    <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (run) begin
                        state <= stFetchLow;
                    end
                end
                stFetchLow: begin
                    ir[7:0] <= fetchByte;  // Low byte comes first
                    pc      <= pc + 8'd1;
                    state   <= stFetchHigh;
                end
                stFetchHigh: begin
                    ir[15:8] <= fetchByte;
                    pc       <= pc + 8'd1;
                    state    <= stExecute;
                end
                stExecute: begin
                    if (ctrl.pcLoad) begin
                        pc <= progAddress'(ctrl.immediate);  // Branch target
                    end
                    // Run low stops only at an instruction boundary
                    if (run) begin
                        state <= stFetchLow;
                    end else begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== controlUnit/instructionDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder
    import cpuArchPkg::*, cpuControlPkg::*;
(
    input  wire instruction ir,
    input  wire logic       execute,
    output controlWord      ctrl
);

    always_comb begin
        // Only the low two bits of each register field matter
        ctrl.regFn     = rfHold;
        ctrl.target    = ir.dst[1:0];
        ctrl.srcA      = ir.srcFirst[1:0];
        ctrl.srcB      = ir.srcSecond[1:0];
        ctrl.op        = aluPassA;
        ctrl.immediate = {ir.srcFirst, ir.srcSecond};
        ctrl.pcLoad    = 1'b0;

        case (ir.code)
            opAnd: begin
                ctrl.op    = aluAnd;
                ctrl.regFn = rfLoad;
            end
            opOr: begin
                ctrl.op    = aluOr;
                ctrl.regFn = rfLoad;
            end
            opNot: begin
                ctrl.op    = aluNot;
                ctrl.regFn = rfLoad;
            end
            opAdd: begin
                ctrl.op    = aluAdd;
                ctrl.regFn = rfLoad;
            end
            opSub: begin
                ctrl.op    = aluSub;
                ctrl.regFn = rfLoad;
            end
            opLsr: begin
                ctrl.op    = aluLsr;
                ctrl.regFn = rfLoad;
            end
            opLsl: begin
                ctrl.op    = aluLsl;
                ctrl.regFn = rfLoad;
            end
            opMov: begin
                ctrl.op    = aluPassA;
                ctrl.regFn = rfLoad;
            end
            opLd: begin
                ctrl.op    = aluPassImm;  // Target is bits 9:8
                ctrl.regFn = rfLoad;
            end
            opInc: begin
                ctrl.target = ir.srcFirst[1:0];  // In place
                ctrl.regFn  = rfIncrement;
            end
            opDec: begin
                ctrl.target = ir.srcFirst[1:0];
                ctrl.regFn  = rfDecrement;
            end
            opBra: begin
                ctrl.pcLoad = 1'b1;
            end
            default: begin
                ctrl.regFn = rfHold;  // Unused codes are no-ops
            end
        endcase

        if (!execute) begin
            ctrl.regFn  = rfHold;
            ctrl.pcLoad = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== registerFile/generalRegister.sv ====
`timescale 1ns/1ps
`default_nettype none

module generalRegister
    import cpuArchPkg::*, cpuControlPkg::*;
(
    input  wire logic       clock,
    input  wire logic       arstN,
    input  wire regIndex    index,
    input  wire controlWord ctrl,
    input  wire dataWord    result,
    output dataWord         value
);

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            value <= '0;
        end else if (ctrl.target == index) begin
            case (ctrl.regFn)
                rfLoad:      value <= result;
                rfIncrement: value <= value + 8'd1;  // Wraps 255 to 0
                rfDecrement: value <= value - 8'd1;  // Wraps 0 to 255
                default:     value <= value;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== registerFile/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile
    import cpuArchPkg::*, cpuControlPkg::*;
(
    input  wire logic       clock,
    input  wire logic       arstN,
    input  wire controlWord ctrl,
    input  wire dataWord    result,
    output dataWord         operandA,
    output dataWord         operandB,
    output registerView     regs
);

    dataWord values [4];

    for (genvar i = 0; i < 4; i++) begin : gReg
        generalRegister i_generalRegister (
            .clock  (clock),
            .arstN  (arstN),
            .index  (regIndex'(i)),
            .ctrl   (ctrl),
            .result (result),
            .value  (values[i])
        );
    end

    // Read muxes into the ALU
    assign operandA = values[ctrl.srcA];
    assign operandB = values[ctrl.srcB];

    assign regs.r1 = values[0];
    assign regs.r2 = values[1];
    assign regs.r3 = values[2];
    assign regs.r4 = values[3];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module cpuTopTb -f sim.f -o cpuTopSim &&
output="$(./obj_dir/cpuTopSim 2>&1 || true)" &&
printf '%s\n' "$output" &&
printf '%s\n' "$output" | grep -q "TEST PASSED" ||
{ echo "Simulation did not pass"; exit 1; }

// ==== sim.f ====
common/cpuArchPkg.sv
common/cpuControlPkg.sv
source/programMemory.sv
controlUnit/controlSequencer.sv
controlUnit/instructionDecoder.sv
registerFile/generalRegister.sv
registerFile/registerFile.sv
source/alu.sv
source/cpuTop.sv
verification/cpuTopTb.sv

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
    import cpuArchPkg::*, cpuControlPkg::*;
(
    input  wire controlWord ctrl,
    input  wire dataWord    operandA,
    input  wire dataWord    operandB,
    output dataWord         result
);

    always_comb begin
        case (ctrl.op)
            aluAnd:     result = operandA & operandB;
            aluOr:      result = operandA | operandB;
            aluNot:     result = ~operandA;
            aluAdd:     result = operandA + operandB;  // Carry dropped
            aluSub:     result = operandA - operandB;
            aluLsr:     result = operandA >> 1;
            aluLsl:     result = operandA << 1;
            aluPassImm: result = ctrl.immediate;
            default:    result = operandA;  // MOV
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop
    import cpuArchPkg::*, cpuControlPkg::*;
(
    input  wire logic       clock,
    input  wire logic       arstN,
    input  wire logic       progWrite,
    input  wire progAddress progAddr,
    input  wire dataWord    progData,
    input  wire logic       run,
    output registerView     regs,
    output progAddress      pc,
    output logic            instrDone
);

    progAddress fetchAddr;
    dataWord    fetchByte;
    instruction ir;
    logic       execute;
    controlWord ctrl;
    dataWord    operandA;
    dataWord    operandB;
    dataWord    result;

    programMemory i_programMemory (
        .clock     (clock),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .fetchAddr (fetchAddr),
        .fetchByte (fetchByte)
    );

    controlSequencer i_controlSequencer (
        .clock     (clock),
        .arstN     (arstN),
        .run       (run),
        .fetchByte (fetchByte),
        .ctrl      (ctrl),
        .fetchAddr (fetchAddr),
        .ir        (ir),
        .execute   (execute),
        .pc        (pc),
        .instrDone (instrDone)
    );

    instructionDecoder i_instructionDecoder (
        .ir      (ir),
        .execute (execute),
        .ctrl    (ctrl)
    );

    registerFile i_registerFile (
        .clock    (clock),
        .arstN    (arstN),
        .ctrl     (ctrl),
        .result   (result),
        .operandA (operandA),
        .operandB (operandB),
        .regs     (regs)
    );

    alu i_alu (
        .ctrl     (ctrl),
        .operandA (operandA),
        .operandB (operandB),
        .result   (result)
    );

endmodule

`default_nettype wire

// ==== source/programMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module programMemory
    import cpuArchPkg::*;
(
    input  wire logic       clock,
    input  wire logic       progWrite,
    input  wire progAddress progAddr,
    input  wire dataWord    progData,
    input  wire progAddress fetchAddr,
    output dataWord         fetchByte
);

    dataWord mem [256];

    always_ff @(posedge clock) begin
        if (progWrite) begin
            mem[progAddr] <= progData;
        end
    end

    assign fetchByte = mem[fetchAddr];  // Read in the same cycle

endmodule

`default_nettype wire

// ==== verification/cpuTopTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTopTb
    import cpuArchPkg::*;
();

    localparam int ldCount      = 4;
    localparam int aluCount     = 24;
    localparam int incDecCount  = 8;
    localparam int branchExec   = 2;  // BRA and the LD at its target
    localparam int branchLoaded = 4;
    localparam int stopCount    = 5;  // One stopped ADD and four unused opcodes
    localparam int execCount    = ldCount + aluCount + incDecCount + branchExec + stopCount;
    localparam int loadBytes    = 2 * (ldCount + aluCount + incDecCount + branchLoaded + stopCount);
    localparam int cycleLimit   = 3 * execCount + loadBytes + 100;

    logic        clock = 1'b0;
    logic        arstN;
    logic        progWrite;
    progAddress  progAddr;
    dataWord     progData;
    logic        run;
    registerView regs;
    progAddress  pc;
    logic        instrDone;

    integer     seed;
    int         cycleCount   = 0;
    logic       checkPending = 1'b0;
    dataWord    tbMem [256];      // Copy of what was written to program memory
    dataWord    modelRegs [4];
    progAddress modelPc;
    progAddress loadPtr;

    cpuTop i_cpuTop (
        .clock     (clock),
        .arstN     (arstN),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .run       (run),
        .regs      (regs),
        .pc        (pc),
        .instrDone (instrDone)
    );

    always #50 clock = ~clock;

    task automatic failRun();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic reportMismatch(string name, logic [7:0] got, logic [7:0] expected);
        $display("** Error at %0d ns: %s is 8'h%h, expected 8'h%h", $time, name, got, expected);
        failRun();
    endtask

    task automatic reportProblem(string what);
        $display("Error at %0t ns: %s", $time, what);
        failRun();
    endtask

    function automatic dataWord registerValue(registerView view, int idx);
        case (idx)
            0:       return view.r1;
            1:       return view.r2;
            2:       return view.r3;
            default: return view.r4;
        endcase
    endfunction

    task automatic compareState();
        for (int i = 0; i < 4; i++) begin
            assert (registerValue(regs, i) == modelRegs[i])
                else reportMismatch($sformatf("regs.r%0d", i + 1), registerValue(regs, i),
                                    modelRegs[i]);
        end
        assert (pc == modelPc) else reportMismatch("pc", pc, modelPc);
    endtask

    // Reference model for one executed instruction
    task automatic applyModel();
        logic [15:0] word;
        logic [1:0]  dst;
        logic [1:0]  srcA;
        logic [1:0]  srcB;
        word    = {tbMem[modelPc + 8'd1], tbMem[modelPc]};  // Low byte sits first
        dst     = word[9:8];
        srcA    = word[5:4];
        srcB    = word[1:0];
        modelPc = modelPc + 8'd2;
        case (word[15:12])
            4'h0: modelRegs[dst] = modelRegs[srcA] & modelRegs[srcB];
            4'h1: modelRegs[dst] = modelRegs[srcA] | modelRegs[srcB];
            4'h2: modelRegs[dst] = ~modelRegs[srcA];
            4'h3: modelRegs[dst] = modelRegs[srcA] + modelRegs[srcB];
            4'h4: modelRegs[dst] = modelRegs[srcA] - modelRegs[srcB];
            4'h5: modelRegs[dst] = {1'b0, modelRegs[srcA][7:1]};
            4'h6: modelRegs[dst] = {modelRegs[srcA][6:0], 1'b0};
            4'h7: modelRegs[srcA] = modelRegs[srcA] + 8'd1;  // In place
            4'h8: modelRegs[srcA] = modelRegs[srcA] - 8'd1;
            4'h9: modelPc = word[7:0];
            4'hB: modelRegs[dst] = modelRegs[srcA];
            4'hC: modelRegs[dst] = word[7:0];
            default: ;  // No-op codes
        endcase
    endtask

    // Results show up one cycle after instrDone
    always @(negedge clock) begin
        if (checkPending) begin
            compareState();
        end
        checkPending = (instrDone === 1'b1);
        if (instrDone === 1'b1) begin
            applyModel();
        end
    end

    always @(negedge clock) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            reportProblem($sformatf("timeout, the test did not end within %0d cycles", cycleLimit));
        end
    end

    task automatic writeByte(progAddress addr, dataWord data);
        @(negedge clock);
        progWrite = 1'b1;
        progAddr  = addr;
        progData  = data;
        tbMem[addr] = data;
    endtask

    task automatic loadInstruction(logic [15:0] word);
        writeByte(loadPtr, word[7:0]);
        writeByte(loadPtr + 8'd1, word[15:8]);
        loadPtr = loadPtr + 8'd2;
    endtask

    task automatic finishLoad();
        @(negedge clock);
        progWrite = 1'b0;
    endtask

    // Run until count instructions are done, dropping run in the last execute cycle
    task automatic runInstructions(int count);
        int seen;
        int gap;
        seen = 0;
        gap  = 0;
        @(negedge clock);
        run = 1'b1;
        while (seen < count) begin
            @(negedge clock);
            gap++;
            if (instrDone) begin
                assert (gap == 3)
                    else reportProblem($sformatf("instrDone came after %0d cycles, not 3", gap));
                seen++;
                gap = 0;
                if (seen == count) begin
                    run = 1'b0;
                end
            end
        end
        @(negedge clock);
    endtask

    initial begin
        logic [3:0]  aluCodes [8];
        progAddress  target;
        dataWord     marker;
        aluCodes  = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'hB};
        seed      = 32'h40d3;
        arstN     = 1'b0;
        run       = 1'b0;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        modelPc   = '0;
        loadPtr   = '0;
        for (int i = 0; i < 4; i++) begin
            modelRegs[i] = '0;
        end
        repeat (2) @(negedge clock);
        arstN = 1'b1;

        @(negedge clock);
        compareState();
        assert (instrDone == 1'b0) else reportMismatch("instrDone", 8'(instrDone), 8'h00);

        for (int r = 0; r < 4; r++) begin
            loadInstruction({4'hC, 2'($random(seed)), 2'(r), 8'($random(seed))});
        end
        finishLoad();
        runInstructions(ldCount);

        for (int k = 0; k < aluCount; k++) begin
            loadInstruction({aluCodes[3'($random(seed))], 4'($random(seed)),
                             4'($random(seed)), 4'($random(seed))});
        end
        finishLoad();
        runInstructions(aluCount);

        loadInstruction({4'hC, 4'h0, 8'hFE});
        loadInstruction({4'h7, 4'($random(seed)), 4'h0, 4'($random(seed))});
        loadInstruction({4'h7, 4'($random(seed)), 4'h4, 4'($random(seed))});  // 255 to 0
        loadInstruction({4'hC, 4'h2, 8'h00});
        loadInstruction({4'h8, 4'($random(seed)), 4'h2, 4'($random(seed))});  // 0 to 255
        for (int k = 0; k < 3; k++) begin
            loadInstruction({4'h7 + 4'(1'($random(seed))), 4'($random(seed)),
                             4'($random(seed)), 4'($random(seed))});
        end
        finishLoad();
        runInstructions(incDecCount);

        target = loadPtr + 8'd6;
        marker = ~modelRegs[0];
        loadInstruction({4'h9, 4'($random(seed)), target});
        loadInstruction({4'hC, 4'h0, marker});  // Skipped by the branch
        loadInstruction({4'hC, 4'h0, marker});
        loadInstruction({4'hC, 4'h1, 8'($random(seed))});
        finishLoad();
        runInstructions(branchExec);

        loadInstruction({4'h3, 4'($random(seed)), 4'($random(seed)), 4'($random(seed))});
        finishLoad();
        @(negedge clock);
        run = 1'b1;
        repeat (2) @(negedge clock);
        run = 1'b0;  // Now in the high byte fetch
        do begin
            @(negedge clock);
        end while (!instrDone);
        @(negedge clock);
        repeat (20) begin
            @(negedge clock);
            assert (instrDone == 1'b0) else reportMismatch("instrDone", 8'(instrDone), 8'h00);
            compareState();
        end

        loadInstruction({4'hA, 4'($random(seed)), 4'($random(seed)), 4'($random(seed))});
        loadInstruction({4'hD, 4'($random(seed)), 4'($random(seed)), 4'($random(seed))});
        loadInstruction({4'hE, 4'($random(seed)), 4'($random(seed)), 4'($random(seed))});
        loadInstruction({4'hF, 4'($random(seed)), 4'($random(seed)), 4'($random(seed))});
        finishLoad();
        runInstructions(stopCount - 1);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
